// ==== tb.f ====
+incdir+source
+incdir+verif
source/dpPkg.sv
source/aluCtrlIf.sv
source/opControl.sv
source/alu.sv
source/regFile.sv
source/datapath.sv
verif/datapathTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the datapath testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f tb.f --top-module datapathTb -o datapathSim

./obj_dir/datapathSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

// ==== verif/dpModel.svh ====
`ifndef DP_MODEL_SVH
`define DP_MODEL_SVH

`include "dpCfg.svh"

// Architectural state as the testbench expects it
word  modelRegs [`REG_COUNT];
logic modelCarry;
logic modelZero;
word  modelResult;

task automatic resetModel();
	for (int i = 0; i < `REG_COUNT; i++)
		modelRegs[i] = '0;
	modelCarry  = 1'b0;
	modelZero   = 1'b0;
	modelResult = '0;
endtask

// Applies one accepted op, the write lands before the next op reads
task automatic applyOp(input microOp op);
	word  a;
	word  b;
	logic cin;
	int   wide;
	word  y;
	logic newCarry;
	logic carryWritten;

	a            = modelRegs[op.ra];
	b            = op.useImm ? op.imm : modelRegs[op.rb];
	cin          = op.carrySel ? modelCarry : op.carryIn;
	y            = '0;
	newCarry     = modelCarry;
	carryWritten = 1'b1;

	case (op.func)
		funcA: begin
			wide     = int'(a) + int'(cin);
			y        = word'(wide);
			newCarry = wide >= (1 << `DATA_WIDTH);
		end
		funcAdd: begin
			wide     = int'(a) + int'(b) + int'(cin);
			y        = word'(wide);
			newCarry = wide >= (1 << `DATA_WIDTH);
		end
		funcSub: begin
			wide     = int'(a) - int'(b) - 1 + int'(cin);
			y        = word'(wide);
			newCarry = wide >= 0; // No borrow
		end
		funcAMinusOne: begin
			wide     = int'(a) - 1 + int'(cin);
			y        = word'(wide);
			newCarry = wide >= 0;
		end
		funcShiftRight: begin
			y        = {1'b0, a[`DATA_WIDTH-1:1]};
			newCarry = a[0];
		end
		funcShiftLeft: begin
			y        = {a[`DATA_WIDTH-2:0], 1'b0};
			newCarry = a[`DATA_WIDTH-1];
		end
		funcB:   carryWritten = 1'b0;
		funcNot: carryWritten = 1'b0;
		funcXor: carryWritten = 1'b0;
		funcAnd: carryWritten = 1'b0;
		funcOr:  carryWritten = 1'b0;
		default: carryWritten = 1'b0; // funcZero and unused codes give zero
	endcase

	// Logic results computed apart from the carry rules
	case (op.func)
		funcB:   y = b;
		funcNot: y = ~a;
		funcXor: y = a ^ b;
		funcAnd: y = a & b;
		funcOr:  y = a | b;
		default: ;
	endcase

	modelResult = y;
	modelZero   = (y == '0);
	if (carryWritten)
		modelCarry = newCarry;
	if (op.writeEn)
		modelRegs[op.rd] = y;
endtask

`endif

// ==== verif/datapathTb.sv ====
`include "dpCfg.svh"

module datapathTb;
	import dpPkg::*;

	`include "dpModel.svh"

	localparam int resetCycles = 10;
	localparam int arithOps    = 60;
	localparam int chainPairs  = 12;
	localparam int logicOps    = 40;
	localparam int shiftOps    = 30;
	localparam int mixedOps    = 150;
	// Cycles of all phases, idle gaps and directed ops included
	localparam int opBudget  = 3 + 2 * `REG_COUNT + arithOps + 4 * chainPairs
		+ 2 * logicOps + shiftOps + 4 + mixedOps + 4;
	localparam int timeLimit = (resetCycles + opBudget + 50) * 10;

	logic       clk = 1'b0;
	logic       arstN;
	logic       opValid;
	logic [4:0] func;
	regAddr     ra;
	regAddr     rb;
	regAddr     rd;
	logic       useImm;
	word        imm;
	logic       carrySel;
	logic       carryIn;
	logic       writeEn;
	logic       resultValid;
	word        result;
	logic       carry;
	logic       zero;

	int   mismatchCount = 0;
	int   strobeErrors  = 0;
	logic expValid      = 1'b0;

	aluFunc arithFuncs [4] = '{funcA, funcSub, funcAdd, funcAMinusOne};
	aluFunc logicFuncs [6] = '{funcB, funcZero, funcNot, funcXor, funcAnd, funcOr};
	aluFunc allFuncs [12] = '{funcA, funcB, funcSub, funcAdd, funcAMinusOne, funcZero,
		funcNot, funcXor, funcAnd, funcOr, funcShiftRight, funcShiftLeft};

	always #5 clk = ~clk;

	datapath datapath_i (
		.clk         (clk),
		.arstN       (arstN),
		.opValid     (opValid),
		.func        (func),
		.ra          (ra),
		.rb          (rb),
		.rd          (rd),
		.useImm      (useImm),
		.imm         (imm),
		.carrySel    (carrySel),
		.carryIn     (carryIn),
		.writeEn     (writeEn),
		.resultValid (resultValid),
		.result      (result),
		.carry       (carry),
		.zero        (zero)
	);

	task automatic checkWord(input string name, input word got, input word exp);
		if (got !== exp) begin
			mismatchCount++;
			$display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatchCount++;
			$display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic checkStrobe(input logic exp);
		if (resultValid !== exp) begin
			strobeErrors++;
			if (exp)
				$display("resultValid did not rise after a valid op at %0t", $time);
			else
				$display("resultValid rose although no op was issued at %0t", $time);
		end
	endtask

	function automatic microOp makeOp(input aluFunc f, input regAddr srcA, input regAddr srcB,
			input regAddr dst, input logic immSel, input word immVal, input logic cSel,
			input logic cIn, input logic wr);
		microOp op;
		op.func     = f;
		op.ra       = srcA;
		op.rb       = srcB;
		op.rd       = dst;
		op.useImm   = immSel;
		op.imm      = immVal;
		op.carrySel = cSel;
		op.carryIn  = cIn;
		op.writeEn  = wr;
		return op;
	endfunction

	function automatic microOp randomOp(input aluFunc f);
		return makeOp(f, regAddr'($urandom()), regAddr'($urandom()), regAddr'($urandom()),
			1'($urandom()), word'($urandom()), 1'b0, 1'($urandom()), 1'b1);
	endfunction

	task automatic issueOp(input microOp op);
		@(posedge clk);
		opValid  <= 1'b1;
		func     <= op.func;
		ra       <= op.ra;
		rb       <= op.rb;
		rd       <= op.rd;
		useImm   <= op.useImm;
		imm      <= op.imm;
		carrySel <= op.carrySel;
		carryIn  <= op.carryIn;
		writeEn  <= op.writeEn;
	endtask

	task automatic idleFor(input int cycles);
		repeat (cycles) begin
			@(posedge clk);
			opValid <= 1'b0;
		end
	endtask

	task automatic loadReg(input regAddr dst, input word value);
		issueOp(makeOp(funcB, '0, '0, dst, 1'b1, value, 1'b0, 1'b0, 1'b1));
	endtask

	// Checks the op sampled at the last rising edge, then models the one now on the inputs
	always @(negedge clk) begin
		microOp cur;
		if (arstN === 1'b1) begin
			checkStrobe(expValid);
			if (expValid)
				checkWord("result", result, modelResult);
			checkFlag("carry", carry, modelCarry);
			checkFlag("zero", zero, modelZero);
			expValid = 1'b0;
			if (opValid) begin
				cur = makeOp(aluFunc'(func), ra, rb, rd, useImm, imm, carrySel, carryIn, writeEn);
				applyOp(cur);
				expValid = 1'b1;
			end
		end
	end

	initial begin
		regAddr lastRd;
		microOp op;
		void'($urandom(32'h3314_d5be));
		resetModel();
		arstN    <= 1'b0;
		opValid  <= 1'b0;
		func     <= '0;
		ra       <= '0;
		rb       <= '0;
		rd       <= '0;
		useImm   <= 1'b0;
		imm      <= '0;
		carrySel <= 1'b0;
		carryIn  <= 1'b0;
		writeEn  <= 1'b0;
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
		idleFor(3); // No strobe before the first op

		// Every register reads back as zero after reset
		for (int r = 0; r < `REG_COUNT; r++)
			issueOp(makeOp(funcB, '0, regAddr'(r), '0, 1'b0, '0, 1'b0, 1'b0, 1'b0));

		for (int r = 0; r < `REG_COUNT; r++)
			loadReg(regAddr'(r), word'($urandom()));

		// Arithmetic with a constant carry-in
		for (int i = 0; i < arithOps; i++)
			issueOp(randomOp(arithFuncs[$urandom_range(3)]));

		// 32-bit adds, high half takes the stored carry
		for (int i = 0; i < chainPairs; i++) begin
			loadReg(3'd1, word'($urandom()));
			loadReg(3'd2, word'($urandom()));
			issueOp(makeOp(funcAdd, 3'd1, '0, 3'd3, 1'b1, word'($urandom()), 1'b0, 1'b0, 1'b1));
			issueOp(makeOp(funcAdd, 3'd2, '0, 3'd4, 1'b1, word'($urandom()), 1'b1, 1'b0, 1'b1));
		end

		// Carry set by an arithmetic op must survive the logic op after it
		for (int i = 0; i < logicOps; i++) begin
			issueOp(randomOp(arithFuncs[$urandom_range(3)]));
			op          = randomOp(logicFuncs[$urandom_range(5)]);
			op.carrySel = 1'($urandom());
			issueOp(op);
		end

		for (int i = 0; i < shiftOps; i++)
			issueOp(randomOp($urandom_range(1) == 0 ? funcShiftRight : funcShiftLeft));

		// A lone bit shifted out leaves zero behind
		loadReg(3'd5, 16'h0001);
		issueOp(makeOp(funcShiftRight, 3'd5, '0, 3'd6, 1'b0, '0, 1'b0, 1'b0, 1'b1));
		loadReg(3'd5, 16'h8000);
		issueOp(makeOp(funcShiftLeft, 3'd5, '0, 3'd6, 1'b0, '0, 1'b0, 1'b0, 1'b1));

		// Back-to-back mix with gaps, sources often the last destination
		lastRd = '0;
		for (int i = 0; i < mixedOps; i++) begin
			if ($urandom_range(9) < 8) begin
				op          = randomOp(allFuncs[$urandom_range(11)]);
				op.carrySel = 1'($urandom());
				op.writeEn  = 1'($urandom());
				if ($urandom_range(1) == 1)
					op.ra = lastRd;
				if ($urandom_range(1) == 1)
					op.rb = lastRd;
				issueOp(op);
				lastRd = op.rd;
			end else begin
				idleFor(1);
			end
		end

		idleFor(4);
		$display("Errors: %0d value mismatches, %0d strobe errors", mismatchCount, strobeErrors);
		if (mismatchCount + strobeErrors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(timeLimit);
		$display("Timeout: the run did not finish within %0d time units", timeLimit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== source/datapath.sv ====
`include "dpCfg.svh"

module datapath (
	input  logic                       clk,
	input  logic                       arstN,
	input  logic                       opValid,
	input  logic [4:0]                 func,
	input  logic [`REG_ADDR_WIDTH-1:0] ra,
	input  logic [`REG_ADDR_WIDTH-1:0] rb,
	input  logic [`REG_ADDR_WIDTH-1:0] rd,
	input  logic                       useImm,
	input  logic [`DATA_WIDTH-1:0]     imm,
	input  logic                       carrySel,
	input  logic                       carryIn,
	input  logic                       writeEn,
	output logic                       resultValid,
	output logic [`DATA_WIDTH-1:0]     result,
	output logic                       carry,
	output logic                       zero
);
	import dpPkg::*;

	microOp op;
	word    rdataA;
	word    rdataB;
	word    aluB;
	word    aluY;
	logic   aluCarry;
	logic   aluZero;
	logic   wrEn;
	regAddr wrAddr;
	word    wrData;

	aluCtrlIf aluCtl ();

	// Gather the op fields
	assign op = '{
		func:     aluFunc'(func),
		ra:       ra,
		rb:       rb,
		rd:       rd,
		useImm:   useImm,
		imm:      imm,
		carrySel: carrySel,
		carryIn:  carryIn,
		writeEn:  writeEn
	};

	opControl opControl_i (
		.clk         (clk),
		.arstN       (arstN),
		.opValid     (opValid),
		.op          (op),
		.regB        (rdataB),
		.aluB        (aluB),
		.aluY        (aluY),
		.aluCarry    (aluCarry),
		.aluZero     (aluZero),
		.ctl         (aluCtl.ctrl),
		.wrEn        (wrEn),
		.wrAddr      (wrAddr),
		.wrData      (wrData),
		.resultValid (resultValid),
		.result      (result),
		.carry       (carry),
		.zero        (zero)
	);

	regFile regFile_i (
		.clk    (clk),
		.arstN  (arstN),
		.raddrA (op.ra),
		.raddrB (op.rb),
		.rdataA (rdataA),
		.rdataB (rdataB),
		.wrEn   (wrEn),
		.wrAddr (wrAddr),
		.wrData (wrData)
	);

	alu alu_i (
		.a        (rdataA),
		.b        (aluB),
		.ctl      (aluCtl.unit),
		.y        (aluY),
		.carryOut (aluCarry),
		.zeroOut  (aluZero)
	);

endmodule

// ==== source/regFile.sv ====
`include "dpCfg.svh"

module regFile (
	input  logic          clk,
	input  logic          arstN,
	input  dpPkg::regAddr raddrA,
	input  dpPkg::regAddr raddrB,
	output dpPkg::word    rdataA,
	output dpPkg::word    rdataB,
	input  logic          wrEn,
	input  dpPkg::regAddr wrAddr,
	input  dpPkg::word    wrData
);
	import dpPkg::*;

	word regs [`REG_COUNT];

	// Asynchronous reads, old value while a write is pending
	assign rdataA = regs[raddrA];
	assign rdataB = regs[raddrB];

	// Single write port
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

endmodule

// ==== source/alu.sv ====
`include "dpCfg.svh"

module alu (
	input  dpPkg::word a,
	input  dpPkg::word b,
	aluCtrlIf.unit     ctl,
	output dpPkg::word y,
	output logic       carryOut,
	output logic       zeroOut
);
	import dpPkg::*;

	logic [`DATA_WIDTH:0] addend; // Second adder input, zero extended
	logic [`DATA_WIDTH:0] sum;    // Carry lands in the top bit
	logic                 arithSel;
	word                  arithY;
	word                  logicY;
	word                  unitY;
	logic                 unitCarry;
	word                  shiftY;
	logic                 shiftCarry;

	// Adder operand select
	always_comb begin
		arithSel = 1'b1;
		case (ctl.func)
			funcA:         addend = '0;
			funcSub:       addend = {1'b0, ~b}; // Carry set means no borrow
			funcAdd:       addend = {1'b0, b};
			funcAMinusOne: addend = {1'b0, {`DATA_WIDTH{1'b1}}};
			default: begin
				addend   = '0;
				arithSel = 1'b0;
			end
		endcase
	end

	assign sum    = {1'b0, a} + addend + {{`DATA_WIDTH{1'b0}}, ctl.cin};
	assign arithY = sum[`DATA_WIDTH-1:0];

	// Logic, pass and zero functions
	always_comb begin
		case (ctl.func)
			funcB:   logicY = b;
			funcNot: logicY = ~a;
			funcXor: logicY = a ^ b;
			funcAnd: logicY = a & b;
			funcOr:  logicY = a | b;
			default: logicY = '0; // funcZero and unused codes
		endcase
	end

	// No carry from the logic side
	assign unitY     = arithSel ? arithY : logicY;
	assign unitCarry = arithSel & sum[`DATA_WIDTH];

	// Shifter, one bit per op
	always_comb begin
		case (ctl.func)
			funcShiftRight: begin
				shiftY     = a >> 1;
				shiftCarry = a[0];
			end
			funcShiftLeft: begin
				shiftY     = a << 1;
				shiftCarry = a[`DATA_WIDTH-1];
			end
			default: begin
				shiftY     = '0;
				shiftCarry = 1'b0;
			end
		endcase
	end

	// Result mux, steered by the two output enables
	always_comb begin
		if (ctl.aluOe) begin
			y        = unitY;
			carryOut = unitCarry;
		end else if (ctl.shiftOe) begin
			y        = shiftY;
			carryOut = shiftCarry;
		end else begin
			y        = '0; // Nothing enabled
			carryOut = 1'b0;
		end
	end

	assign zeroOut = (y == '0);

endmodule

// ==== source/opControl.sv ====
module opControl (
	input  logic          clk,
	input  logic          arstN,
	input  logic          opValid,
	input  dpPkg::microOp op,
	input  dpPkg::word    regB,
	output dpPkg::word    aluB,
	input  dpPkg::word    aluY,
	input  logic          aluCarry,
	input  logic          aluZero,
	aluCtrlIf.ctrl        ctl,
	output logic          wrEn,
	output dpPkg::regAddr wrAddr,
	output dpPkg::word    wrData,
	output logic          resultValid,
	output dpPkg::word    result,
	output logic          carry,
	output logic          zero
);
	import dpPkg::*;

	logic isShift;
	logic affectsCarry;

	// Function decode
	always_comb begin
		isShift      = 1'b0;
		affectsCarry = 1'b0;
		case (op.func)
			funcShiftRight,
			funcShiftLeft: begin
				isShift      = 1'b1;
				affectsCarry = 1'b1;
			end
			funcA,
			funcSub,
			funcAdd,
			funcAMinusOne: affectsCarry = 1'b1;
			default: affectsCarry = 1'b0; // Logic, pass and zero keep carry
		endcase
	end

	// ALU control
	assign ctl.func    = op.func;
	assign ctl.shiftOe = isShift;
	assign ctl.aluOe   = !isShift;
	assign ctl.cin     = op.carrySel ? carry : op.carryIn;

	// Immediate takes the place of the second register
	assign aluB = op.useImm ? op.imm : regB;

	// Writeback, sampled by the register file at the closing edge
	assign wrEn   = opValid & op.writeEn;
	assign wrAddr = op.rd;
	assign wrData = aluY;

	// Flags and result strobe
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resultValid <= 1'b0;
			carry       <= 1'b0;
			zero        <= 1'b0;
		end else begin
			resultValid <= opValid;
			if (opValid) begin
				zero <= aluZero;
				if (affectsCarry)
					carry <= aluCarry;
			end
		end
	end

	// Result held until the next valid op
	always_ff @(posedge clk) begin
		if (opValid)
			result <= aluY;
	end

endmodule

// ==== source/aluCtrlIf.sv ====
interface aluCtrlIf;
	import dpPkg::*;

	aluFunc func;
	logic   cin;
	logic   aluOe;   // Function unit drives the result
	logic   shiftOe; // Shifter drives the result

	modport ctrl (
		output func,
		output cin,
		output aluOe,
		output shiftOe
	);

	modport unit (
		input func,
		input cin,
		input aluOe,
		input shiftOe
	);

endinterface

// ==== source/dpPkg.sv ====
`include "dpCfg.svh"

package dpPkg;

	typedef logic [`DATA_WIDTH-1:0] word;
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr;

	// ALU function codes, shifts sit in their own group
	typedef enum logic [4:0] {
		funcA          = 5'h00, // a + cin
		funcB          = 5'h01, // Pass b
		funcSub        = 5'h02, // a - b - 1 + cin
		funcAdd        = 5'h03, // a + b + cin
		funcAMinusOne  = 5'h04, // a - 1 + cin
		funcZero       = 5'h05,
		funcNot        = 5'h06,
		funcXor        = 5'h07,
		funcAnd        = 5'h08,
		funcOr         = 5'h09,
		funcShiftRight = 5'h10,
		funcShiftLeft  = 5'h11  // Bit 0 picks left
	} aluFunc;

	// One micro-operation as issued to the datapath
	typedef struct packed {
		aluFunc func;
		regAddr ra;
		regAddr rb;
		regAddr rd;
		logic   useImm;   // Immediate replaces operand b
		word    imm;
		logic   carrySel; // 1 takes the stored carry flag
		logic   carryIn;  // Microcode carry constant
		logic   writeEn;
	} microOp;

endpackage

// ==== source/dpCfg.svh ====
`ifndef DP_CFG_SVH
`define DP_CFG_SVH

// Datapath word width
`define DATA_WIDTH 16

// Register file depth
`define REG_COUNT 8

// Must cover REG_COUNT
`define REG_ADDR_WIDTH 3

`endif
